/* sd_cmd_pkg.sv */
// Command indices, response kinds, command error codes and frame widths for the SPI command layer
package sd_cmd_pkg;

    // Command indices sent during SPI-mode initialisation
    typedef enum logic [5:0] {
        CMD0   = 6'd0,
        CMD8   = 6'd8,
        ACMD41 = 6'd41,
        CMD55  = 6'd55,
        CMD58  = 6'd58
    } sd_cmd_e;

    // R1 is a single status byte, R3 and R7 append a 32-bit word
    typedef enum logic {
        R1   = 1'b0,
        R3R7 = 1'b1
    } sd_resp_e;

    typedef enum logic [1:0] {
        NONE        = 2'd0,
        NO_RESPONSE = 2'd1
    } cmd_err_e;

    typedef logic [31:0] cmd_arg_t;

    localparam int FRAME_BITS  = 48;
    localparam int R1_BITS     = 8;
    localparam int R3R7_BITS   = 40;
    localparam int R1_IDLE_BIT = 0;

endpackage

/* sd_card_pkg.sv */
// Card types, initialisation states, OCR and CMD8 argument field constants
package sd_card_pkg;

    typedef enum logic [2:0] {
        UNKNOWN  = 3'd0,
        VER1X_SC = 3'd1,
        VER2X_SC = 3'd2,
        VER2X_HC = 3'd3,
        UNUSABLE = 3'd4
    } card_type_e;

    // Each command state first issues its command, then waits for the answer
    typedef enum logic [2:0] {
        INIT_IDLE,
        INIT_PRE,
        INIT_CMD0,
        INIT_CMD8,
        INIT_CMD55,
        INIT_ACMD41,
        INIT_CMD58,
        INIT_DONE
    } init_state_e;

    // SCLK cycles with chip select high before the first command
    localparam int PRE_INIT_CLOCKS = 74;

    // CMD8 argument fields, VHS in bits 11..8 and check pattern in bits 7..0
    localparam logic [3:0] CMD8_VHS     = 4'b0001;
    localparam logic [7:0] CMD8_PATTERN = 8'hAA;

    // Host capacity support in the ACMD41 argument
    localparam int HCS_BIT = 30;

    // Card capacity status in the OCR returned by CMD58
    localparam int OCR_CCS_BIT = 30;

endpackage

/* sd_cmd_if.sv */
// Command request and response bundle between the init sequencer and the command transmitter
`timescale 1ns/100ps

interface sd_cmd_if;

    // Request side, req is a one-cycle strobe
    logic                  req;
    sd_cmd_pkg::sd_cmd_e   cmd;
    sd_cmd_pkg::cmd_arg_t  arg;
    sd_cmd_pkg::sd_resp_e  resp_kind;

    // Response side, done is a one-cycle strobe
    logic                  done;
    logic [7:0]            r1;
    sd_cmd_pkg::cmd_arg_t  payload;
    sd_cmd_pkg::cmd_err_e  err;

    modport seq (output req, cmd, arg, resp_kind, input done, r1, payload, err);
    modport trx (input req, cmd, arg, resp_kind, output done, r1, payload, err);

endinterface

/* sd_clk_gen.sv */
// SCLK divider with rising and falling edge strobes
`timescale 1ns/100ps

module sd_clk_gen #(
    parameter int CLK_DIV = 4
) (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_run,
    output logic o_sclk,
    output logic o_sclk_rise,
    output logic o_sclk_fall
);

    localparam int CNT_W = $clog2(CLK_DIV + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);

    logic [CNT_W-1:0] div_cnt;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            div_cnt     <= '0;
            o_sclk      <= 1'b0;
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
        end else if (!i_run) begin
            // Parked low while the controller is idle
            div_cnt     <= '0;
            o_sclk      <= 1'b0;
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
        end else if (div_cnt == CNT_LAST) begin
            div_cnt     <= '0;
            o_sclk      <= ~o_sclk;
            o_sclk_rise <= ~o_sclk;
            o_sclk_fall <= o_sclk;
        end else begin
            div_cnt     <= div_cnt + 1'b1;
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
        end
    end

endmodule

/* sd_crc7.sv */
// Serial CRC7 generator for command frames
`timescale 1ns/100ps

module sd_crc7 (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_clear,
    input  logic       i_next,
    input  logic       i_dat,
    output logic [6:0] o_crc7
);

    logic fb;

    // Polynomial x^7 + x^3 + 1
    assign fb = i_dat ^ o_crc7[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_crc7 <= '0;
        end else if (i_clear) begin
            o_crc7 <= '0;
        end else if (i_next) begin
            o_crc7 <= {o_crc7[5:3], o_crc7[2] ^ fb, o_crc7[1:0], fb};
        end
    end

endmodule

/* sd_cmd_trx.sv */
// SPI command frame serialiser, response deserialiser and response timeout
`timescale 1ns/100ps

module sd_cmd_trx #(
    parameter int RESP_WAIT_BITS = 64
) (
    input  logic  i_clk,
    input  logic  i_nrst,
    input  logic  i_sclk_rise,
    input  logic  i_sclk_fall,
    input  logic  i_miso,
    output logic  o_mosi,
    output logic  o_cs_n,
    sd_cmd_if.trx cmd
);

    localparam int WAIT_W = $clog2(RESP_WAIT_BITS + 1);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(RESP_WAIT_BITS - 1);
    localparam logic [5:0] CRC_POS = 6'd40;
    localparam logic [5:0] END_POS = 6'(sd_cmd_pkg::FRAME_BITS);
    localparam logic [5:0] GAP_LAST = 6'd7;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_TX,
        ST_WAIT,
        ST_RX,
        ST_GAP
    } trx_state_e;

    trx_state_e           state;
    logic [5:0]           bit_cnt;
    logic [WAIT_W-1:0]    wait_cnt;
    logic                 pend;
    logic [47:0]          tx_sh;
    logic [38:0]          rx_sh;
    logic [39:0]          rx_word;
    logic [5:0]           rx_last;
    sd_cmd_pkg::sd_resp_e kind;
    logic                 tx_shift;
    logic                 crc_next;
    logic                 resp_end;
    logic                 resp_timeout;
    logic [6:0]           crc7;

    // One frame bit leaves on every falling edge until the end bit is out
    assign tx_shift = i_sclk_fall && ((state == ST_IDLE && pend) ||
                                      (state == ST_TX && bit_cnt != END_POS));
    assign crc_next = tx_shift && (bit_cnt < CRC_POS);

    // The start bit doubles as bit 7 of R1 and is counted in the response
    assign rx_word = {rx_sh, i_miso};
    assign rx_last = (kind == sd_cmd_pkg::R1) ? 6'(sd_cmd_pkg::R1_BITS - 1)
                                              : 6'(sd_cmd_pkg::R3R7_BITS - 1);
    assign resp_end = i_sclk_rise && (state == ST_RX) && (bit_cnt == rx_last);
    assign resp_timeout = i_sclk_rise && (state == ST_WAIT) && i_miso &&
                          (wait_cnt == WAIT_LAST);

    sd_crc7 crc7_inst (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (cmd.req),
        .i_next  (crc_next),
        .i_dat   (tx_sh[47]),
        .o_crc7  (crc7)
    );

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            wait_cnt <= '0;
            pend     <= 1'b0;
            o_mosi   <= 1'b1;
            o_cs_n   <= 1'b1;
            cmd.done <= 1'b0;
            cmd.err  <= sd_cmd_pkg::NONE;
        end else begin
            cmd.done <= 1'b0;
            if (cmd.req) begin
                pend <= 1'b1;
            end
            if (tx_shift) begin
                o_mosi  <= (bit_cnt == CRC_POS) ? crc7[6] : tx_sh[47];
                bit_cnt <= bit_cnt + 6'd1;
            end
            case (state)
                ST_IDLE: begin
                    if (tx_shift) begin
                        state  <= ST_TX;
                        pend   <= 1'b0;
                        o_cs_n <= 1'b0;
                    end
                end
                ST_TX: begin
                    // End bit has been on the line for a full SCLK period
                    if (i_sclk_fall && bit_cnt == END_POS) begin
                        state    <= ST_WAIT;
                        wait_cnt <= '0;
                        o_mosi   <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (i_sclk_rise && !i_miso) begin
                        state   <= ST_RX;
                        bit_cnt <= 6'd1;
                    end else if (resp_timeout) begin
                        state    <= ST_GAP;
                        bit_cnt  <= '0;
                        o_cs_n   <= 1'b1;
                        cmd.done <= 1'b1;
                        cmd.err  <= sd_cmd_pkg::NO_RESPONSE;
                    end else if (i_sclk_rise) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_RX: begin
                    if (resp_end) begin
                        state    <= ST_GAP;
                        bit_cnt  <= '0;
                        o_cs_n   <= 1'b1;
                        cmd.done <= 1'b1;
                        cmd.err  <= sd_cmd_pkg::NONE;
                    end else if (i_sclk_rise) begin
                        bit_cnt <= bit_cnt + 6'd1;
                    end
                end
                default: begin
                    // Eight SCLK cycles with chip select high between frames
                    if (i_sclk_rise) begin
                        if (bit_cnt == GAP_LAST) begin
                            state   <= ST_IDLE;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 6'd1;
                        end
                    end
                end
            endcase
        end
    end

    // Frame and response shift registers
    always_ff @(posedge i_clk) begin
        if (cmd.req) begin
            tx_sh <= {2'b01, cmd.cmd, cmd.arg, 8'hFF};
            kind  <= cmd.resp_kind;
        end else if (tx_shift) begin
            if (bit_cnt == CRC_POS) begin
                // CRC7 and end bit follow the 40 header and argument bits
                tx_sh <= {crc7[5:0], {42{1'b1}}};
            end else begin
                tx_sh <= {tx_sh[46:0], 1'b1};
            end
        end
        if (i_sclk_rise && (state == ST_WAIT || state == ST_RX)) begin
            rx_sh <= rx_word[38:0];
        end
        if (resp_end) begin
            cmd.r1      <= (kind == sd_cmd_pkg::R1) ? rx_word[7:0] : rx_word[39:32];
            cmd.payload <= rx_word[31:0];
        end else if (resp_timeout) begin
            cmd.r1 <= 8'hFF;
        end
    end

endmodule

/* sd_init_seq.sv */
// SPI-mode initialisation FSM and card-type decision
`timescale 1ns/100ps

module sd_init_seq (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_start,
    input  logic                    i_sclk_rise,
    output logic                    o_run,
    output logic                    o_busy,
    output logic                    o_done,
    output sd_card_pkg::card_type_e o_card_type,
    sd_cmd_if.seq                   cmd
);

    localparam logic [6:0] PRE_LAST = 7'(sd_card_pkg::PRE_INIT_CLOCKS - 1);
    localparam sd_cmd_pkg::cmd_arg_t CMD8_ARG =
        {20'd0, sd_card_pkg::CMD8_VHS, sd_card_pkg::CMD8_PATTERN};

    sd_card_pkg::init_state_e state;
    logic                     wait_resp;
    logic [6:0]               pre_cnt;
    logic                     hcs;
    logic                     r1_bad;
    logic                     resp_fail;
    sd_cmd_pkg::cmd_arg_t     acmd41_arg;

    assign o_busy = (state != sd_card_pkg::INIT_IDLE);
    assign o_done = (state == sd_card_pkg::INIT_DONE);
    // SCLK runs for the whole initialisation
    assign o_run  = o_busy;

    // Any R1 error flag apart from the idle bit
    assign r1_bad    = (cmd.r1 & ~(8'd1 << sd_cmd_pkg::R1_IDLE_BIT)) != 8'd0;
    assign resp_fail = (cmd.err != sd_cmd_pkg::NONE) || r1_bad;

    assign acmd41_arg = sd_cmd_pkg::cmd_arg_t'(hcs) << sd_card_pkg::HCS_BIT;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state         <= sd_card_pkg::INIT_IDLE;
            wait_resp     <= 1'b0;
            pre_cnt       <= '0;
            hcs           <= 1'b1;
            o_card_type   <= sd_card_pkg::UNKNOWN;
            cmd.req       <= 1'b0;
            cmd.cmd       <= sd_cmd_pkg::CMD0;
            cmd.arg       <= '0;
            cmd.resp_kind <= sd_cmd_pkg::R1;
        end else begin
            cmd.req <= 1'b0;
            case (state)
                sd_card_pkg::INIT_IDLE: begin
                    if (i_start) begin
                        state       <= sd_card_pkg::INIT_PRE;
                        pre_cnt     <= '0;
                        hcs         <= 1'b1;
                        o_card_type <= sd_card_pkg::UNKNOWN;
                    end
                end
                sd_card_pkg::INIT_PRE: begin
                    if (i_sclk_rise) begin
                        pre_cnt <= pre_cnt + 7'd1;
                        if (pre_cnt == PRE_LAST) begin
                            state <= sd_card_pkg::INIT_CMD0;
                        end
                    end
                end
                sd_card_pkg::INIT_DONE: begin
                    state <= sd_card_pkg::INIT_IDLE;
                end
                default: begin
                    if (!wait_resp) begin
                        // Issue the command that belongs to this state
                        wait_resp     <= 1'b1;
                        cmd.req       <= 1'b1;
                        cmd.arg       <= '0;
                        cmd.resp_kind <= sd_cmd_pkg::R1;
                        case (state)
                            sd_card_pkg::INIT_CMD0: begin
                                cmd.cmd <= sd_cmd_pkg::CMD0;
                            end
                            sd_card_pkg::INIT_CMD8: begin
                                cmd.cmd       <= sd_cmd_pkg::CMD8;
                                cmd.arg       <= CMD8_ARG;
                                cmd.resp_kind <= sd_cmd_pkg::R3R7;
                            end
                            sd_card_pkg::INIT_CMD55: begin
                                cmd.cmd <= sd_cmd_pkg::CMD55;
                            end
                            sd_card_pkg::INIT_ACMD41: begin
                                cmd.cmd <= sd_cmd_pkg::ACMD41;
                                cmd.arg <= acmd41_arg;
                            end
                            default: begin
                                cmd.cmd       <= sd_cmd_pkg::CMD58;
                                cmd.resp_kind <= sd_cmd_pkg::R3R7;
                            end
                        endcase
                    end else if (cmd.done) begin
                        wait_resp <= 1'b0;
                        case (state)
                            sd_card_pkg::INIT_CMD0: begin
                                // Stay here and resend until the card reports idle
                                if (cmd.err == sd_cmd_pkg::NONE && cmd.r1 == 8'h01) begin
                                    state <= sd_card_pkg::INIT_CMD8;
                                end
                            end
                            sd_card_pkg::INIT_CMD8: begin
                                if (cmd.err == sd_cmd_pkg::NO_RESPONSE) begin
                                    // Version 1 card supports standard capacity only
                                    o_card_type <= sd_card_pkg::VER1X_SC;
                                    hcs         <= 1'b0;
                                    state       <= sd_card_pkg::INIT_CMD55;
                                end else if (r1_bad ||
                                        cmd.payload[7:0] != sd_card_pkg::CMD8_PATTERN) begin
                                    o_card_type <= sd_card_pkg::UNUSABLE;
                                    state       <= sd_card_pkg::INIT_DONE;
                                end else begin
                                    state <= sd_card_pkg::INIT_CMD55;
                                end
                            end
                            sd_card_pkg::INIT_CMD55: begin
                                if (resp_fail) begin
                                    o_card_type <= sd_card_pkg::UNUSABLE;
                                    state       <= sd_card_pkg::INIT_DONE;
                                end else begin
                                    state <= sd_card_pkg::INIT_ACMD41;
                                end
                            end
                            sd_card_pkg::INIT_ACMD41: begin
                                if (resp_fail) begin
                                    o_card_type <= sd_card_pkg::UNUSABLE;
                                    state       <= sd_card_pkg::INIT_DONE;
                                end else if (cmd.r1[sd_cmd_pkg::R1_IDLE_BIT]) begin
                                    state <= sd_card_pkg::INIT_CMD55;
                                end else begin
                                    state <= sd_card_pkg::INIT_CMD58;
                                end
                            end
                            default: begin
                                if (resp_fail) begin
                                    o_card_type <= sd_card_pkg::UNUSABLE;
                                end else if (o_card_type != sd_card_pkg::VER1X_SC) begin
                                    o_card_type <= cmd.payload[sd_card_pkg::OCR_CCS_BIT] ?
                                                   sd_card_pkg::VER2X_HC : sd_card_pkg::VER2X_SC;
                                end
                                state <= sd_card_pkg::INIT_DONE;
                            end
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

/* sd_spi_init_top.sv */
// Top level of the SPI-mode SD card initialisation controller
`timescale 1ns/100ps

module sd_spi_init_top #(
    parameter int CLK_DIV        = 4,
    parameter int RESP_WAIT_BITS = 64
) (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_start,
    input  logic                    i_miso,
    output logic                    o_sclk,
    output logic                    o_mosi,
    output logic                    o_cs_n,
    output logic                    o_busy,
    output logic                    o_done,
    output sd_card_pkg::card_type_e o_card_type
);

    logic run;
    logic sclk_rise;
    logic sclk_fall;

    sd_cmd_if cmd_if ();

    sd_clk_gen #(
        .CLK_DIV (CLK_DIV)
    ) sd_clk_gen_inst (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_run       (run),
        .o_sclk      (o_sclk),
        .o_sclk_rise (sclk_rise),
        .o_sclk_fall (sclk_fall)
    );

    sd_cmd_trx #(
        .RESP_WAIT_BITS (RESP_WAIT_BITS)
    ) sd_cmd_trx_inst (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_sclk_rise (sclk_rise),
        .i_sclk_fall (sclk_fall),
        .i_miso      (i_miso),
        .o_mosi      (o_mosi),
        .o_cs_n      (o_cs_n),
        .cmd         (cmd_if.trx)
    );

    sd_init_seq sd_init_seq_inst (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_start     (i_start),
        .i_sclk_rise (sclk_rise),
        .o_run       (run),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_card_type (o_card_type),
        .cmd         (cmd_if.seq)
    );

endmodule

/* sd_spi_init_props.sv */
// Concurrent assertions on the SPI pins and start/done handshake of the init controller
`timescale 1ns/100ps

module sd_spi_init_props (
    input logic i_clk,
    input logic i_nrst,
    input logic i_sclk,
    input logic i_mosi,
    input logic i_cs_n,
    input logic i_busy,
    input logic i_done
);

    logic       sclk_q;
    logic [7:0] rises;

    // SCLK rises since the run began, saturating
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            sclk_q <= 1'b0;
            rises  <= '0;
        end else begin
            sclk_q <= i_sclk;
            if (!i_busy) begin
                rises <= '0;
            end else if (i_sclk && !sclk_q && rises != 8'hFF) begin
                rises <= rises + 8'd1;
            end
        end
    end

    done_one_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_done |=> !i_done)
        else $error("o_done held high for more than one cycle");

    mosi_high_when_deselected: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_cs_n |-> i_mosi)
        else $error("o_mosi low while o_cs_n is high");

    cs_high_when_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !i_busy |-> i_cs_n)
        else $error("o_cs_n low while the controller is idle");

    done_only_when_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_done |-> i_busy)
        else $error("o_done raised while o_busy is low");

    pre_init_before_frame: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $fell(i_cs_n) |-> (rises >= 8'(sd_card_pkg::PRE_INIT_CLOCKS)))
        else $error("chip select fell before the pre-init SCLK cycles were done");

endmodule

bind sd_spi_init_top sd_spi_init_props sd_spi_init_props_inst (
    .i_clk  (i_clk),
    .i_nrst (i_nrst),
    .i_sclk (o_sclk),
    .i_mosi (o_mosi),
    .i_cs_n (o_cs_n),
    .i_busy (o_busy),
    .i_done (o_done)
);

/* tb_sd_spi_init.sv */
// Testbench with clock, SD card model, golden-file reader, compare tasks and run timeout
`timescale 1ns/100ps

module tb_sd_spi_init;

    localparam int CLK_DIV        = 4;
    localparam int RESP_WAIT_BITS = 64;
    localparam int MAX_CMDS       = 64;
    localparam int MAX_SCEN       = 8;

    logic                    i_clk;
    logic                    i_nrst;
    logic                    i_start;
    logic                    i_miso;
    logic                    o_sclk;
    logic                    o_mosi;
    logic                    o_cs_n;
    logic                    o_busy;
    logic                    o_done;
    sd_card_pkg::card_type_e o_card_type;

    // Golden data with one entry per command frame
    sd_cmd_pkg::sd_cmd_e     exp_cmd [MAX_CMDS];
    sd_cmd_pkg::cmd_arg_t    exp_arg [MAX_CMDS];
    logic [6:0]              exp_crc [MAX_CMDS];
    int                      fill_bytes [MAX_CMDS];
    int                      no_resp [MAX_CMDS];
    int                      resp_bytes [MAX_CMDS];
    logic [39:0]             resp_val [MAX_CMDS];
    string                   scen_name [MAX_SCEN];
    int                      scen_first [MAX_SCEN];
    int                      scen_last [MAX_SCEN];
    sd_card_pkg::card_type_e scen_type [MAX_SCEN];
    int                      n_cmds;
    int                      n_scen;

    // Card model state
    int                      cur_scen;
    int                      cmd_ptr;
    int                      frame_cnt;
    logic [47:0]             frame_sh;
    logic                    responding;
    logic                    sclk_q;
    bit                      miso_q [$];
    int                      pre_rises;
    logic                    frame_seen;
    longint                  cycle_cnt;
    longint                  cycle_limit;

    sd_spi_init_top #(
        .CLK_DIV        (CLK_DIV),
        .RESP_WAIT_BITS (RESP_WAIT_BITS)
    ) sd_spi_init_top_inst (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_start     (i_start),
        .i_miso      (i_miso),
        .o_sclk      (o_sclk),
        .o_mosi      (o_mosi),
        .o_cs_n      (o_cs_n),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_card_type (o_card_type)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles",
                                cycle_limit));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_frame(
        input string                name,
        input sd_cmd_pkg::sd_cmd_e  exp_c,
        input sd_cmd_pkg::sd_cmd_e  got_c,
        input sd_cmd_pkg::cmd_arg_t exp_a,
        input sd_cmd_pkg::cmd_arg_t got_a,
        input logic [6:0]           exp_k,
        input logic [6:0]           got_k
    );
        if (got_c != exp_c) begin
            abort_run($sformatf("Fail %s index: expected %0d, got %0d", name, exp_c, got_c));
        end else if (got_a != exp_a) begin
            abort_run($sformatf("Fail %s argument: expected %h, got %h", name, exp_a, got_a));
        end else if (got_k != exp_k) begin
            abort_run($sformatf("Fail %s CRC7: expected %h, got %h", name, exp_k, got_k));
        end
    endtask

    task automatic check_card_type(
        input string                   name,
        input sd_card_pkg::card_type_e exp_t,
        input sd_card_pkg::card_type_e got_t
    );
        if (got_t != exp_t) begin
            abort_run($sformatf("Fail %s card type: expected %s, got %s",
                                name, exp_t.name(), got_t.name()));
        end
    endtask

    // Token-based reader that skips lines starting with #
    task automatic load_golden();
        int          fd;
        int          r;
        string       tok;
        string       rest;
        logic [5:0]  idx;
        logic [31:0] arg;
        logic [6:0]  crc;
        int          fill;
        int          nr;
        int          nb;
        logic [39:0] rv;
        int          t;
        n_cmds = 0;
        n_scen = 0;
        fd = $fopen("sd_init_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the golden file sd_init_golden.txt");
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    r = $fgets(rest, fd);
                end else if (tok == "S") begin
                    r = $fscanf(fd, "%s", rest);
                    scen_name[n_scen]  = rest;
                    scen_first[n_scen] = n_cmds;
                end else if (tok == "C") begin
                    r = $fscanf(fd, "%h %h %h %d %d %d %h", idx, arg, crc, fill, nr, nb, rv);
                    if (r != 7) begin
                        abort_run($sformatf("Golden file command entry %0d is incomplete",
                                            n_cmds));
                    end else begin
                        exp_cmd[n_cmds]    = sd_cmd_pkg::sd_cmd_e'(idx);
                        exp_arg[n_cmds]    = arg;
                        exp_crc[n_cmds]    = crc;
                        fill_bytes[n_cmds] = fill;
                        no_resp[n_cmds]    = nr;
                        resp_bytes[n_cmds] = nb;
                        resp_val[n_cmds]   = rv;
                        n_cmds++;
                    end
                end else if (tok == "E") begin
                    r = $fscanf(fd, "%d", t);
                    scen_type[n_scen] = sd_card_pkg::card_type_e'(t);
                    scen_last[n_scen] = n_cmds;
                    n_scen++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Called at the rise that completes a 48-bit frame
    task automatic answer_frame();
        string name;
        int    i;
        name = $sformatf("%s cmd %0d", scen_name[cur_scen], cmd_ptr - scen_first[cur_scen]);
        if (cmd_ptr >= scen_last[cur_scen]) begin
            abort_run($sformatf("%s: the card got more frames than the golden file lists",
                                scen_name[cur_scen]));
        end else if (!frame_seen && pre_rises < sd_card_pkg::PRE_INIT_CLOCKS) begin
            abort_run($sformatf("%s: only %0d SCLK rises with chip select high before CMD0",
                                name, pre_rises));
        end else if (frame_sh[47:46] != 2'b01 || !frame_sh[0]) begin
            abort_run($sformatf("%s: frame %h has a wrong start, transmission or end bit",
                                name, frame_sh));
        end else begin
            frame_seen = 1'b1;
            check_frame(name, exp_cmd[cmd_ptr], sd_cmd_pkg::sd_cmd_e'(frame_sh[45:40]),
                        exp_arg[cmd_ptr], frame_sh[39:8], exp_crc[cmd_ptr], frame_sh[7:1]);
            if (no_resp[cmd_ptr] == 0) begin
                for (i = 0; i < fill_bytes[cmd_ptr] * 8; i++) begin
                    miso_q.push_back(1'b1);
                end
                for (i = resp_bytes[cmd_ptr] * 8 - 1; i >= 0; i--) begin
                    miso_q.push_back(resp_val[cmd_ptr][i]);
                end
            end
            cmd_ptr++;
        end
    endtask

    // Card model takes MOSI at SCLK rises and moves MISO after SCLK falls
    always @(negedge i_clk) begin
        if (o_cs_n) begin
            frame_cnt  = 0;
            responding = 1'b0;
            miso_q.delete();
            i_miso = 1'b1;
            if (o_sclk && !sclk_q && !frame_seen) begin
                pre_rises++;
            end
        end else if (o_sclk && !sclk_q && !responding) begin
            frame_sh = {frame_sh[46:0], o_mosi};
            frame_cnt++;
            if (frame_cnt == sd_cmd_pkg::FRAME_BITS) begin
                answer_frame();
                responding = 1'b1;
            end
        end else if (!o_sclk && sclk_q && responding) begin
            if (miso_q.size() > 0) begin
                i_miso = miso_q.pop_front();
            end else begin
                i_miso = 1'b1;
            end
        end
        sclk_q = o_sclk;
    end

    task automatic run_scenario(input int s);
        cur_scen   = s;
        cmd_ptr    = scen_first[s];
        pre_rises  = 0;
        frame_seen = 1'b0;
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        if (!o_busy) begin
            abort_run($sformatf("%s: o_busy did not rise after i_start", scen_name[s]));
        end
        // A start pulse while the first frame is on the line must be ignored
        while (o_cs_n) begin
            @(negedge i_clk);
        end
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        while (!o_done) begin
            @(negedge i_clk);
        end
        if (cmd_ptr != scen_last[s]) begin
            abort_run($sformatf("%s: run ended after %0d of %0d frames", scen_name[s],
                                cmd_ptr - scen_first[s], scen_last[s] - scen_first[s]));
        end else begin
            check_card_type(scen_name[s], scen_type[s], o_card_type);
        end
        @(negedge i_clk);
        if (o_busy) begin
            abort_run($sformatf("%s: o_busy still high after o_done", scen_name[s]));
        end
    endtask

    initial begin
        i_clk      = 1'b0;
        i_nrst     = 1'b0;
        i_start    = 1'b0;
        i_miso     = 1'b1;
        sclk_q     = 1'b0;
        responding = 1'b0;
        frame_cnt  = 0;
        frame_sh   = '0;
        pre_rises  = 0;
        frame_seen = 1'b0;
        cur_scen   = 0;
        cmd_ptr    = 0;
        cycle_cnt  = 0;
        load_golden();
        // Room for two spare commands and for the pre-init of every run
        cycle_limit = longint'(n_cmds + 2) * (sd_cmd_pkg::FRAME_BITS + RESP_WAIT_BITS + 48)
                      * 2 * CLK_DIV
                      + longint'(n_scen) * ((sd_card_pkg::PRE_INIT_CLOCKS + 2) * 2 * CLK_DIV + 30)
                      + 20;
        repeat (10) @(negedge i_clk);
        i_nrst = 1'b1;
        for (int s = 0; s < n_scen; s++) begin
            run_scenario(s);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

/* sd_init_golden.txt */
# S name | C index arg crc7 filler_bytes no_resp resp_bytes resp_hex | E expected card type
# Card type codes are 1 VER1X_SC, 2 VER2X_SC, 3 VER2X_HC, 4 UNUSABLE
S v2_hc
C 00 00000000 4a 1 0 1 01
C 08 000001aa 43 2 0 5 01000001aa
C 37 00000000 32 1 0 1 01
C 29 40000000 3b 1 0 1 01
C 37 00000000 32 0 0 1 01
C 29 40000000 3b 3 0 1 00
C 3a 00000000 7e 1 0 5 00c0ff8000
E 3
S v2_sc
C 00 00000000 4a 0 0 1 01
C 08 000001aa 43 1 0 5 01000001aa
C 37 00000000 32 1 0 1 01
C 29 40000000 3b 1 0 1 00
C 3a 00000000 7e 2 0 5 0000ff8000
E 2
S v1_sc
C 00 00000000 4a 1 0 1 01
C 08 000001aa 43 0 1 0 00
C 37 00000000 32 1 0 1 01
C 29 00000000 72 1 0 1 01
C 37 00000000 32 1 0 1 01
C 29 00000000 72 1 0 1 00
C 3a 00000000 7e 1 0 5 0000ff8000
E 1
S cmd0_retry_bad_echo
C 00 00000000 4a 0 1 0 00
C 00 00000000 4a 1 0 1 01
C 08 000001aa 43 1 0 5 0100000155
E 4

/* compile.f */
sd_cmd_pkg.sv
sd_card_pkg.sv
sd_cmd_if.sv
sd_clk_gen.sv
sd_crc7.sv
sd_cmd_trx.sv
sd_init_seq.sv
sd_spi_init_top.sv
sd_spi_init_props.sv
tb_sd_spi_init.sv

/* Makefile */
TOOL       = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_sd_spi_init
FILE_LIST  = compile.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
